// ==== design/tx_buffer_pkg.sv ====
package tx_buffer_pkg;

  //------------------------------
  // Widths
  //------------------------------

  // 256 words per bank
  localparam int TX_ADDR_WIDTH = 8;
  localparam int TX_WORD_WIDTH = 64;
  localparam int TX_WORD_BYTES = 8;

  typedef logic [TX_WORD_WIDTH-1:0] word_t;
  typedef logic [TX_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [2:0]               byte_lo_t;
  typedef logic [TX_ADDR_WIDTH+2:0] byte_count_t;
  // Valid bytes in the last word, 0 to 8
  typedef logic [3:0]               last_bytes_t;
  typedef logic [15:0]              csum_t;

  //------------------------------
  // Bank states
  //------------------------------

  // Order matters, the full flag compares against BANK_HAS_DATA
  typedef enum logic [2:0] {
    BANK_EMPTY,
    BANK_HAS_DATA,
    BANK_CHECKSUM,
    BANK_FIFO_OUT,
    BANK_FIFO_TRANSMIT
  } bank_state_t;

  localparam word_addr_t ADDR_LAST        = '1;
  localparam word_addr_t ADDR_ALMOST_LAST = ADDR_LAST - 1'b1;

endpackage

// ==== design/tx_ram_if.sv ====
`timescale 1ns/1ps

interface tx_ram_if import tx_buffer_pkg::*; ();

  // Write side
  logic       wr_en;
  word_addr_t wr_addr;
  word_t      wr_data;

  // Read side, rd_data follows rd_en by one cycle
  logic       rd_en;
  word_addr_t rd_addr;
  word_t      rd_data;

  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// ==== design/tx_buffer_ram.sv ====
`timescale 1ns/1ps

module tx_buffer_ram import tx_buffer_pkg::*; (
  tx_ram_if.mem ram,
  input  logic  i_clk
);

  word_t mem [0:(1 << TX_ADDR_WIDTH)-1];

  always_ff @(posedge i_clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
  end

  // Read data holds while rd_en is low
  always_ff @(posedge i_clk) begin
    if (ram.rd_en) begin
      ram.rd_data <= mem[ram.rd_addr];
    end
  end

endmodule

// ==== design/internet_checksum.sv ====
`timescale 1ns/1ps

module internet_checksum import tx_buffer_pkg::*; (
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_sum_reset,
  input  csum_t       i_sum_reset_value,
  input  logic        i_start,
  input  word_addr_t  i_start_addr,
  input  byte_count_t i_bytes,
  output logic        o_rd_en,
  output word_addr_t  o_rd_addr,
  input  word_t       i_rd_data,
  output logic        o_fetch_done,
  output csum_t       o_sum,
  output logic        o_sum_done
);

  logic                     busy;
  word_addr_t               rd_addr;
  byte_count_t              remaining;
  logic                     last_issue;
  logic                     fetch_done;
  logic [TX_WORD_BYTES-1:0] mask_next;
  logic [TX_WORD_BYTES-1:0] mask_q;
  logic                     data_valid;
  word_t                    masked;
  csum_t                    s0_sum_next;
  logic [1:0]               s0_carry_next;
  csum_t                    s0_sum;
  logic [1:0]               s0_carry;
  logic                     s0_valid;
  logic                     s0_last;
  csum_t                    acc;
  csum_t                    acc_next;
  logic                     sum_done;

  //------------------------------
  // Read sequencer
  //------------------------------

  assign last_issue = busy && (remaining <= byte_count_t'(TX_WORD_BYTES));

  // Mask bit 7 is byte 0, the top byte of the word
  assign mask_next = (remaining >= byte_count_t'(TX_WORD_BYTES)) ? '1 :
                     ~(8'hff >> remaining[3:0]);

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      busy       <= 1'b0;
      rd_addr    <= '0;
      remaining  <= '0;
      fetch_done <= 1'b0;
      data_valid <= 1'b0;
    end else begin
      // A zero byte count still sends a done token down the pipeline
      fetch_done <= last_issue || (i_start && (i_bytes == '0));
      data_valid <= busy;
      if (i_start) begin
        busy      <= (i_bytes != '0);
        rd_addr   <= i_start_addr;
        remaining <= i_bytes;
      end else if (busy) begin
        busy      <= !last_issue;
        rd_addr   <= rd_addr + 1'b1;
        remaining <= last_issue ? '0 : remaining - byte_count_t'(TX_WORD_BYTES);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (busy) begin
      mask_q <= mask_next;
    end
  end

  //------------------------------
  // Stage 0, carry-save adds
  //------------------------------

  always_comb begin
    csum_t pair_a;
    csum_t pair_b;
    logic  c_a;
    logic  c_b;
    logic  c_s;
    for (int i = 0; i < TX_WORD_BYTES; i++) begin
      masked[8*i +: 8] = mask_q[i] ? i_rd_data[8*i +: 8] : 8'h00;
    end
    {c_a, pair_a} = {1'b0, masked[63:48]} + {1'b0, masked[47:32]};
    {c_b, pair_b} = {1'b0, masked[31:16]} + {1'b0, masked[15:0]};
    {c_s, s0_sum_next} = {1'b0, pair_a} + {1'b0, pair_b};
    s0_carry_next = {1'b0, c_a} + {1'b0, c_b} + {1'b0, c_s};
  end

  always_ff @(posedge i_clk) begin
    s0_sum   <= s0_sum_next;
    s0_carry <= s0_carry_next;
  end

  //------------------------------
  // Stage 1, end-around fold
  //------------------------------

  always_comb begin
    csum_t      sum_d;
    logic       c_d;
    logic [2:0] carries;
    csum_t      sum_e;
    logic       c_e;
    {c_d, sum_d} = {1'b0, acc} + {1'b0, s0_sum};
    carries = {1'b0, s0_carry} + {2'b00, c_d};
    {c_e, sum_e} = {1'b0, sum_d} + {14'h0, carries};
    // Cannot overflow again, sum_e is tiny whenever c_e is set
    acc_next = sum_e + {15'h0, c_e};
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      s0_valid <= 1'b0;
      s0_last  <= 1'b0;
      acc      <= '0;
      sum_done <= 1'b0;
    end else begin
      s0_valid <= data_valid;
      s0_last  <= fetch_done;
      sum_done <= s0_last;
      // Preload wins over a word in flight
      if (i_sum_reset) begin
        acc <= i_sum_reset_value;
      end else if (s0_valid) begin
        acc <= acc_next;
      end
    end
  end

  assign o_rd_en      = busy;
  assign o_rd_addr    = rd_addr;
  assign o_fetch_done = fetch_done;
  assign o_sum        = acc;
  assign o_sum_done   = sum_done;

endmodule

// ==== design/tx_buffer_ctrl.sv ====
`timescale 1ns/1ps

module tx_buffer_ctrl import tx_buffer_pkg::*; (
  input  logic        i_clk,
  input  logic        i_areset,
  tx_ram_if.ctrl      bank0,
  tx_ram_if.ctrl      bank1,
  input  logic        i_parser_clear,
  input  logic        i_write_en,
  input  word_t       i_write_data,
  input  word_addr_t  i_address_hi,
  input  byte_lo_t    i_address_lo,
  input  logic        i_parser_update_length,
  input  logic        i_parser_transfer,
  input  logic        i_sum_en,
  input  byte_count_t i_sum_bytes,
  input  logic        i_dispatch_tx_fifo_rd_start,
  input  logic        i_dispatch_tx_packet_read,
  output logic        o_sum_start,
  output word_addr_t  o_sum_word_addr,
  output byte_count_t o_sum_bytes,
  input  logic        i_sum_rd_en,
  input  word_addr_t  i_sum_rd_addr,
  output word_t       o_sum_rd_data,
  input  logic        i_fetch_done,
  output logic        o_error,
  output logic        o_parser_current_empty,
  output logic        o_parser_current_memory_full,
  output logic        o_dispatch_tx_packet_available,
  output logic        o_dispatch_tx_fifo_empty,
  output logic        o_dispatch_tx_fifo_rd_valid,
  output word_t       o_dispatch_tx_fifo_rd_data,
  output last_bytes_t o_dispatch_tx_bytes_last_word
);

  // Per-bank state, ptr is the write pointer for the parser bank
  // and the read pointer for the FIFO bank
  bank_state_t state      [2];
  word_addr_t  ptr        [2];
  word_addr_t  count      [2];
  last_bytes_t last_bytes [2];

  logic        cur;
  logic        p;
  logic        f;
  logic        parser_empty;
  logic        write_ok;
  word_addr_t  wr_addr;
  logic        sum_start;
  logic        tx_active;
  logic        fifo_issue;
  logic        fifo_valid_d;
  logic        bad_cmd;
  word_t       rd_data [2];

  logic        avail_q;
  logic        empty_q;
  logic        valid_q;
  word_t       data_q;
  last_bytes_t last_q;

  assign p = cur;
  assign f = ~cur;

  assign parser_empty = (state[p] == BANK_EMPTY);
  assign write_ok     = i_write_en && !i_parser_clear &&
                        (parser_empty || (state[p] == BANK_HAS_DATA));
  assign wr_addr      = parser_empty ? '0 : ptr[p];
  assign sum_start    = i_sum_en && (state[p] == BANK_HAS_DATA) &&
                        !i_parser_clear && !i_parser_transfer;
  assign fifo_issue   = (state[f] == BANK_FIFO_TRANSMIT) && tx_active;

  //------------------------------
  // RAM port steering
  //------------------------------

  assign bank0.wr_en   = write_ok && !cur;
  assign bank1.wr_en   = write_ok && cur;
  assign bank0.wr_addr = wr_addr;
  assign bank1.wr_addr = wr_addr;
  assign bank0.wr_data = i_write_data;
  assign bank1.wr_data = i_write_data;

  // Checksum reads go to the parser bank, FIFO reads to the other one
  assign bank0.rd_en   = cur ? fifo_issue : i_sum_rd_en;
  assign bank0.rd_addr = cur ? ptr[0] : i_sum_rd_addr;
  assign bank1.rd_en   = cur ? i_sum_rd_en : fifo_issue;
  assign bank1.rd_addr = cur ? i_sum_rd_addr : ptr[1];

  assign rd_data[0] = bank0.rd_data;
  assign rd_data[1] = bank1.rd_data;

  assign o_sum_start     = sum_start;
  assign o_sum_word_addr = i_address_hi;
  assign o_sum_bytes     = i_sum_bytes;
  assign o_sum_rd_data   = rd_data[p];

  //------------------------------
  // Bank state machines
  //------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      cur          <= 1'b0;
      bad_cmd      <= 1'b0;
      tx_active    <= 1'b0;
      fifo_valid_d <= 1'b0;
      for (int b = 0; b < 2; b++) begin
        state[b]      <= BANK_EMPTY;
        ptr[b]        <= '0;
        count[b]      <= '0;
        last_bytes[b] <= '0;
      end
    end else begin
      bad_cmd      <= parser_empty &&
                      (i_sum_en || i_parser_update_length || i_parser_transfer);
      fifo_valid_d <= fifo_issue;

      // Parser bank
      if (i_parser_clear) begin
        state[p] <= BANK_EMPTY;
        ptr[p]   <= '0;
      end else begin
        case (state[p])
          BANK_EMPTY: begin
            if (i_write_en) begin
              state[p]      <= BANK_HAS_DATA;
              ptr[p]        <= word_addr_t'(1);
              count[p]      <= '0;
              last_bytes[p] <= last_bytes_t'(TX_WORD_BYTES);
            end
          end
          BANK_HAS_DATA: begin
            // Without a length update the packet is every written word
            if (i_write_en) begin
              ptr[p]        <= ptr[p] + 1'b1;
              count[p]      <= ptr[p];
              last_bytes[p] <= last_bytes_t'(TX_WORD_BYTES);
            end
            if (i_parser_update_length) begin
              if (i_address_lo != '0) begin
                count[p]      <= i_address_hi;
                last_bytes[p] <= {1'b0, i_address_lo};
              end else if (i_address_hi != '0) begin
                count[p]      <= i_address_hi - 1'b1;
                last_bytes[p] <= last_bytes_t'(TX_WORD_BYTES);
              end else begin
                count[p]      <= '0;
                last_bytes[p] <= '0;
              end
            end
            if (sum_start) begin
              state[p] <= BANK_CHECKSUM;
            end
            if (i_parser_transfer) begin
              state[p] <= BANK_FIFO_OUT;
            end
          end
          BANK_CHECKSUM: begin
            if (i_fetch_done) begin
              state[p] <= BANK_HAS_DATA;
            end
          end
          BANK_FIFO_OUT: begin
            // Swap roles once the other bank is free
            if (state[f] == BANK_EMPTY) begin
              cur    <= ~cur;
              ptr[p] <= '0;
            end
          end
          default: ;
        endcase
      end

      // FIFO bank
      case (state[f])
        BANK_FIFO_OUT: begin
          if (i_dispatch_tx_fifo_rd_start) begin
            state[f]  <= BANK_FIFO_TRANSMIT;
            tx_active <= (last_bytes[f] != '0);
          end
        end
        BANK_FIFO_TRANSMIT: begin
          if (fifo_issue) begin
            ptr[f] <= ptr[f] + 1'b1;
            if (ptr[f] == count[f]) begin
              tx_active <= 1'b0;
            end
          end
        end
        default: ;
      endcase
      if (i_dispatch_tx_packet_read &&
          ((state[f] == BANK_FIFO_OUT) || (state[f] == BANK_FIFO_TRANSMIT))) begin
        state[f]  <= BANK_EMPTY;
        tx_active <= 1'b0;
      end
    end
  end

  //------------------------------
  // Dispatcher output registers
  //------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      avail_q <= 1'b0;
      empty_q <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= '0;
    end else begin
      avail_q <= (state[f] == BANK_FIFO_OUT);
      empty_q <= (state[f] == BANK_FIFO_TRANSMIT) && !tx_active;
      valid_q <= fifo_valid_d;
      last_q  <= last_bytes[f];
    end
  end

  always_ff @(posedge i_clk) begin
    data_q <= rd_data[f];
  end

  assign o_error                        = bad_cmd;
  assign o_parser_current_empty         = parser_empty;
  assign o_parser_current_memory_full   =
    ((state[p] == BANK_HAS_DATA) &&
     ((ptr[p] == ADDR_LAST) || ((ptr[p] == ADDR_ALMOST_LAST) && i_write_en))) ||
    (state[p] > BANK_HAS_DATA);
  assign o_dispatch_tx_packet_available = avail_q;
  assign o_dispatch_tx_fifo_empty       = empty_q;
  assign o_dispatch_tx_fifo_rd_valid    = valid_q;
  assign o_dispatch_tx_fifo_rd_data     = data_q;
  assign o_dispatch_tx_bytes_last_word  = last_q;

endmodule

// ==== design/nts_tx_buffer.sv ====
`timescale 1ns/1ps

module nts_tx_buffer import tx_buffer_pkg::*; (
  input  logic        i_clk,
  input  logic        i_areset,

  // Parser side
  input  logic        i_parser_clear,
  input  logic        i_write_en,
  input  word_t       i_write_data,
  input  word_addr_t  i_address_hi,
  input  byte_lo_t    i_address_lo,
  input  logic        i_parser_update_length,
  input  logic        i_parser_transfer,
  output logic        o_parser_current_empty,
  output logic        o_parser_current_memory_full,
  output logic        o_error,

  // Checksum
  input  logic        i_sum_reset,
  input  csum_t       i_sum_reset_value,
  input  logic        i_sum_en,
  input  byte_count_t i_sum_bytes,
  output csum_t       o_sum,
  output logic        o_sum_done,

  // Dispatcher side
  output logic        o_dispatch_tx_packet_available,
  input  logic        i_dispatch_tx_packet_read,
  output logic        o_dispatch_tx_fifo_empty,
  input  logic        i_dispatch_tx_fifo_rd_start,
  output logic        o_dispatch_tx_fifo_rd_valid,
  output word_t       o_dispatch_tx_fifo_rd_data,
  output last_bytes_t o_dispatch_tx_bytes_last_word
);

  logic        sum_start;
  word_addr_t  sum_word_addr;
  byte_count_t sum_bytes;
  logic        sum_rd_en;
  word_addr_t  sum_rd_addr;
  word_t       sum_rd_data;
  logic        fetch_done;

  tx_ram_if bank0_if ();
  tx_ram_if bank1_if ();

  tx_buffer_ram u_ram0 (
    .ram   (bank0_if),
    .i_clk (i_clk)
  );

  tx_buffer_ram u_ram1 (
    .ram   (bank1_if),
    .i_clk (i_clk)
  );

  tx_buffer_ctrl u_ctrl (
    .i_clk                          (i_clk),
    .i_areset                       (i_areset),
    .bank0                          (bank0_if),
    .bank1                          (bank1_if),
    .i_parser_clear                 (i_parser_clear),
    .i_write_en                     (i_write_en),
    .i_write_data                   (i_write_data),
    .i_address_hi                   (i_address_hi),
    .i_address_lo                   (i_address_lo),
    .i_parser_update_length         (i_parser_update_length),
    .i_parser_transfer              (i_parser_transfer),
    .i_sum_en                       (i_sum_en),
    .i_sum_bytes                    (i_sum_bytes),
    .i_dispatch_tx_fifo_rd_start    (i_dispatch_tx_fifo_rd_start),
    .i_dispatch_tx_packet_read      (i_dispatch_tx_packet_read),
    .o_sum_start                    (sum_start),
    .o_sum_word_addr                (sum_word_addr),
    .o_sum_bytes                    (sum_bytes),
    .i_sum_rd_en                    (sum_rd_en),
    .i_sum_rd_addr                  (sum_rd_addr),
    .o_sum_rd_data                  (sum_rd_data),
    .i_fetch_done                   (fetch_done),
    .o_error                        (o_error),
    .o_parser_current_empty         (o_parser_current_empty),
    .o_parser_current_memory_full   (o_parser_current_memory_full),
    .o_dispatch_tx_packet_available (o_dispatch_tx_packet_available),
    .o_dispatch_tx_fifo_empty       (o_dispatch_tx_fifo_empty),
    .o_dispatch_tx_fifo_rd_valid    (o_dispatch_tx_fifo_rd_valid),
    .o_dispatch_tx_fifo_rd_data     (o_dispatch_tx_fifo_rd_data),
    .o_dispatch_tx_bytes_last_word  (o_dispatch_tx_bytes_last_word)
  );

  internet_checksum u_csum (
    .i_clk             (i_clk),
    .i_areset          (i_areset),
    .i_sum_reset       (i_sum_reset),
    .i_sum_reset_value (i_sum_reset_value),
    .i_start           (sum_start),
    .i_start_addr      (sum_word_addr),
    .i_bytes           (sum_bytes),
    .o_rd_en           (sum_rd_en),
    .o_rd_addr         (sum_rd_addr),
    .i_rd_data         (sum_rd_data),
    .o_fetch_done      (fetch_done),
    .o_sum             (o_sum),
    .o_sum_done        (o_sum_done)
  );

endmodule

// ==== testbench/tb_nts_tx_buffer.sv ====
`timescale 1ns/1ps

module tb_nts_tx_buffer import tx_buffer_pkg::*; ();

  localparam int CLK_PERIOD    = 8;
  localparam int DRIVE_DELAY   = 1;
  localparam int RESET_CYCLES  = 16;
  localparam int FLAG_TIMEOUT  = 64;

  // Rough cycle budget per test group
  localparam int ROUND_CYCLES  = 3 * 40;
  localparam int CSUM_CYCLES   = 7 * 20 + 60;
  localparam int PINGPONG_CYCLES = 120;
  localparam int FULL_CYCLES   = 300;
  localparam int TOTAL_CYCLES  = RESET_CYCLES + 20 + ROUND_CYCLES + CSUM_CYCLES +
                                 PINGPONG_CYCLES + FULL_CYCLES;

  localparam int WAIT_SUM_DONE   = 0;
  localparam int WAIT_FIFO_EMPTY = 1;
  localparam int WAIT_AVAILABLE  = 2;

  logic        i_clk;
  logic        i_areset;
  logic        i_parser_clear;
  logic        i_write_en;
  word_t       i_write_data;
  word_addr_t  i_address_hi;
  byte_lo_t    i_address_lo;
  logic        i_parser_update_length;
  logic        i_parser_transfer;
  logic        o_parser_current_empty;
  logic        o_parser_current_memory_full;
  logic        o_error;
  logic        i_sum_reset;
  csum_t       i_sum_reset_value;
  logic        i_sum_en;
  byte_count_t i_sum_bytes;
  csum_t       o_sum;
  logic        o_sum_done;
  logic        o_dispatch_tx_packet_available;
  logic        i_dispatch_tx_packet_read;
  logic        o_dispatch_tx_fifo_empty;
  logic        i_dispatch_tx_fifo_rd_start;
  logic        o_dispatch_tx_fifo_rd_valid;
  word_t       o_dispatch_tx_fifo_rd_data;
  last_bytes_t o_dispatch_tx_bytes_last_word;

  integer      seed;
  word_t       wr_q [$];
  word_t       exp_q [$];
  word_t       rx_q [$];
  word_t       pkt_a_q [$];

  nts_tx_buffer UUT (
    .i_clk                          (i_clk),
    .i_areset                       (i_areset),
    .i_parser_clear                 (i_parser_clear),
    .i_write_en                     (i_write_en),
    .i_write_data                   (i_write_data),
    .i_address_hi                   (i_address_hi),
    .i_address_lo                   (i_address_lo),
    .i_parser_update_length         (i_parser_update_length),
    .i_parser_transfer              (i_parser_transfer),
    .o_parser_current_empty         (o_parser_current_empty),
    .o_parser_current_memory_full   (o_parser_current_memory_full),
    .o_error                        (o_error),
    .i_sum_reset                    (i_sum_reset),
    .i_sum_reset_value              (i_sum_reset_value),
    .i_sum_en                       (i_sum_en),
    .i_sum_bytes                    (i_sum_bytes),
    .o_sum                          (o_sum),
    .o_sum_done                     (o_sum_done),
    .o_dispatch_tx_packet_available (o_dispatch_tx_packet_available),
    .i_dispatch_tx_packet_read      (i_dispatch_tx_packet_read),
    .o_dispatch_tx_fifo_empty       (o_dispatch_tx_fifo_empty),
    .i_dispatch_tx_fifo_rd_start    (i_dispatch_tx_fifo_rd_start),
    .o_dispatch_tx_fifo_rd_valid    (o_dispatch_tx_fifo_rd_valid),
    .o_dispatch_tx_fifo_rd_data     (o_dispatch_tx_fifo_rd_data),
    .o_dispatch_tx_bytes_last_word  (o_dispatch_tx_bytes_last_word)
  );

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // Receiver samples at the falling edge where outputs are stable
  always @(negedge i_clk) begin
    if (o_dispatch_tx_fifo_rd_valid === 1'b1) begin
      rx_q.push_back(o_dispatch_tx_fifo_rd_data);
    end
  end

  initial begin
    #(TOTAL_CYCLES * 4 * CLK_PERIOD);
    abort_run("watchdog expired before all tests completed");
  end

  //------------------------------
  // Reference model
  //------------------------------

  function automatic logic [7:0] byte_at(input int idx);
    word_t w;
    w = wr_q[idx / 8];
    // Byte 0 is the top byte of the word
    return w[8 * (7 - idx % 8) +: 8];
  endfunction

  function automatic csum_t ref_checksum(input csum_t preload, input int start_word,
                                         input int nbytes);
    int unsigned s;
    logic [7:0]  hi;
    logic [7:0]  lo;
    s = preload;
    for (int i = 0; i < nbytes; i += 2) begin
      hi = byte_at(start_word * 8 + i);
      lo = (i + 1 < nbytes) ? byte_at(start_word * 8 + i + 1) : 8'h00;
      s = s + {hi, lo};
      s = (s & 32'hffff) + (s >> 16);
    end
    return s[15:0];
  endfunction

  function automatic last_bytes_t ref_last_bytes(input int len);
    if (len == 0) begin
      return 4'd0;
    end
    return (len % 8 == 0) ? 4'd8 : 4'(len % 8);
  endfunction

  //------------------------------
  // Checking helpers
  //------------------------------

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic wait_flag(input int sel, input string name);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen) begin
      @(negedge i_clk);
      case (sel)
        WAIT_SUM_DONE:   seen = (o_sum_done === 1'b1);
        WAIT_FIFO_EMPTY: seen = (o_dispatch_tx_fifo_empty === 1'b1);
        default:         seen = (o_dispatch_tx_packet_available === 1'b1);
      endcase
      cycles++;
      if (!seen && cycles > FLAG_TIMEOUT) begin
        abort_run({"timed out waiting for ", name});
      end
    end
  endtask

  //------------------------------
  // Stimulus helpers
  //------------------------------

  task automatic advance();
    @(posedge i_clk);
    #DRIVE_DELAY;
  endtask

  task automatic write_words(input int n);
    word_t w;
    wr_q.delete();
    for (int i = 0; i < n; i++) begin
      advance();
      w = {$random(seed), $random(seed)};
      i_write_en   = 1'b1;
      i_write_data = w;
      wr_q.push_back(w);
    end
    advance();
    i_write_en = 1'b0;
  endtask

  task automatic set_length_and_transfer(input int len);
    advance();
    i_parser_update_length = 1'b1;
    i_address_hi           = word_addr_t'(len / 8);
    i_address_lo           = byte_lo_t'(len % 8);
    advance();
    i_parser_update_length = 1'b0;
    i_parser_transfer      = 1'b1;
    advance();
    i_parser_transfer = 1'b0;
  endtask

  // Reads one packet and compares it with exp_q
  task automatic read_packet(input int len);
    int n;
    n = (len + 7) / 8;
    wait_flag(WAIT_AVAILABLE, "o_dispatch_tx_packet_available");
    rx_q.delete();
    advance();
    i_dispatch_tx_fifo_rd_start = 1'b1;
    advance();
    i_dispatch_tx_fifo_rd_start = 1'b0;
    wait_flag(WAIT_FIFO_EMPTY, "o_dispatch_tx_fifo_empty");
    @(negedge i_clk);
    check_value("word count", rx_q.size(), n);
    for (int i = 0; i < n; i++) begin
      check_value("o_dispatch_tx_fifo_rd_data", rx_q[i], exp_q[i]);
    end
    check_value("o_dispatch_tx_bytes_last_word", o_dispatch_tx_bytes_last_word,
                ref_last_bytes(len));
    advance();
    i_dispatch_tx_packet_read = 1'b1;
    advance();
    i_dispatch_tx_packet_read = 1'b0;
    @(negedge i_clk);
    @(negedge i_clk);
    check_value("o_dispatch_tx_packet_available", o_dispatch_tx_packet_available, 0);
    check_value("o_dispatch_tx_fifo_empty", o_dispatch_tx_fifo_empty, 0);
  endtask

  task automatic run_checksum(input int start_word, input int nbytes);
    integer rnd;
    csum_t  preload;
    rnd     = $random(seed);
    preload = rnd[15:0];
    advance();
    i_sum_reset       = 1'b1;
    i_sum_reset_value = preload;
    advance();
    i_sum_reset  = 1'b0;
    i_sum_en     = 1'b1;
    i_address_hi = word_addr_t'(start_word);
    i_sum_bytes  = byte_count_t'(nbytes);
    advance();
    i_sum_en = 1'b0;
    wait_flag(WAIT_SUM_DONE, "o_sum_done");
    check_value("o_sum", o_sum, ref_checksum(preload, start_word, nbytes));
    if (nbytes == 0) begin
      check_value("o_sum", o_sum, preload);
    end
  endtask

  //------------------------------
  // Main sequence
  //------------------------------

  initial begin
    seed                        = 42012;
    i_clk                       = 1'b0;
    i_areset                    = 1'b1;
    i_parser_clear              = 1'b0;
    i_write_en                  = 1'b0;
    i_write_data                = '0;
    i_address_hi                = '0;
    i_address_lo                = '0;
    i_parser_update_length      = 1'b0;
    i_parser_transfer           = 1'b0;
    i_sum_reset                 = 1'b0;
    i_sum_reset_value           = '0;
    i_sum_en                    = 1'b0;
    i_sum_bytes                 = '0;
    i_dispatch_tx_packet_read   = 1'b0;
    i_dispatch_tx_fifo_rd_start = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    #DRIVE_DELAY;
    i_areset = 1'b0;

    // Flags after reset and a command on an empty bank
    @(negedge i_clk);
    check_value("o_parser_current_empty", o_parser_current_empty, 1);
    check_value("o_parser_current_memory_full", o_parser_current_memory_full, 0);
    check_value("o_error", o_error, 0);
    check_value("o_sum_done", o_sum_done, 0);
    check_value("o_dispatch_tx_packet_available", o_dispatch_tx_packet_available, 0);
    check_value("o_dispatch_tx_fifo_empty", o_dispatch_tx_fifo_empty, 0);
    check_value("o_dispatch_tx_fifo_rd_valid", o_dispatch_tx_fifo_rd_valid, 0);
    advance();
    i_sum_en = 1'b1;
    advance();
    i_sum_en = 1'b0;
    @(negedge i_clk);
    check_value("o_error", o_error, 1);
    @(negedge i_clk);
    check_value("o_error", o_error, 0);

    // Round trips with one spare word beyond the length
    begin
      int lens [3];
      lens = '{13, 16, 1};
      for (int k = 0; k < 3; k++) begin
        write_words((lens[k] + 7) / 8 + 1);
        exp_q = wr_q;
        set_length_and_transfer(lens[k]);
        read_packet(lens[k]);
      end
    end

    // Checksums over six words that must still read back afterwards
    write_words(6);
    for (int a = 0; a <= 2; a += 2) begin
      run_checksum(a, 24);
      run_checksum(a, 13);
      run_checksum(a, 1);
    end
    run_checksum(0, 0);
    exp_q = wr_q;
    set_length_and_transfer(48);
    read_packet(48);

    // Ping-pong with B waiting behind A
    write_words(3);
    set_length_and_transfer(20);
    wait_flag(WAIT_AVAILABLE, "o_dispatch_tx_packet_available");
    pkt_a_q = wr_q;
    write_words(2);
    set_length_and_transfer(11);
    repeat (4) @(negedge i_clk);
    check_value("o_dispatch_tx_packet_available", o_dispatch_tx_packet_available, 1);
    check_value("o_parser_current_memory_full", o_parser_current_memory_full, 1);
    check_value("o_parser_current_empty", o_parser_current_empty, 0);
    exp_q = pkt_a_q;
    read_packet(20);
    exp_q = wr_q;
    read_packet(11);
    check_value("o_parser_current_empty", o_parser_current_empty, 1);

    // Full flag
    write_words(254);
    @(negedge i_clk);
    check_value("o_parser_current_memory_full", o_parser_current_memory_full, 0);
    write_words(1);
    @(negedge i_clk);
    check_value("o_parser_current_memory_full", o_parser_current_memory_full, 1);
    advance();
    i_parser_clear = 1'b1;
    advance();
    i_parser_clear = 1'b0;
    @(negedge i_clk);
    check_value("o_parser_current_memory_full", o_parser_current_memory_full, 0);
    check_value("o_parser_current_empty", o_parser_current_empty, 1);

    $display("Test passed");
    $finish;
  end

endmodule

// ==== sim.f ====
design/tx_buffer_pkg.sv
design/tx_ram_if.sv
design/tx_buffer_ram.sv
design/internet_checksum.sv
design/tx_buffer_ctrl.sv
design/nts_tx_buffer.sv
testbench/tb_nts_tx_buffer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the packet buffer testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing -Wno-fatal --top-module tb_nts_tx_buffer \
  -f sim.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$output"
echo "Simulator exit status: $status"

if grep -qx "Test passed" <<< "$output"; then
  exit 0
else
  exit 1
fi
